//--- Makefile
TOP = bt_bridge_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- filelist.f
source/bt_link_pkg.sv
source/uart_byte_if.sv
source/byte_fifo.sv
source/uart_tx_engine.sv
source/uart_rx_engine.sv
source/at_sequencer.sv
source/bt_bridge.sv
tests/bt_bridge_tb.sv

//--- source/at_sequencer.sv
// Command sequencer that sends the queued AT bytes, then holds busy until the reply is read out
`timescale 1ns/1ps
`default_nettype none

module at_sequencer
	import bt_link_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire send_i,
	input wire cmd_empty_i,
	input wire byte_t cmd_head_i,
	output logic cmd_pop_o,
	uart_byte_if.sender link,
	input wire line_feed_i,
	input wire resp_empty_i,
	output logic busy_o,
	output logic resp_done_o
);

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_LAUNCH,
		SEQ_WAIT_DONE,
		SEQ_AWAIT_REPLY,
		SEQ_DELIVER
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;
	logic lf_seen;

	// FIFO head stays put until the pop on done
	assign link.data = cmd_head_i;
	assign link.start = (state == SEQ_LAUNCH) && !cmd_empty_i;
	assign cmd_pop_o = (state == SEQ_WAIT_DONE) && link.done;

	assign busy_o = (state != SEQ_IDLE);
	assign resp_done_o = lf_seen;

	always_comb
	begin
		state_next = state;
		case (state)
			SEQ_IDLE:
			begin
				if (send_i && !cmd_empty_i)
				begin
					state_next = SEQ_LAUNCH;
				end
			end
			SEQ_LAUNCH:
			begin
				// Command drained, now listen for the reply
				if (cmd_empty_i)
				begin
					state_next = SEQ_AWAIT_REPLY;
				end
				else
				begin
					state_next = SEQ_WAIT_DONE;
				end
			end
			SEQ_WAIT_DONE:
			begin
				if (link.done)
				begin
					state_next = SEQ_LAUNCH;
				end
			end
			SEQ_AWAIT_REPLY:
			begin
				if (lf_seen)
				begin
					state_next = SEQ_DELIVER;
				end
			end
			SEQ_DELIVER:
			begin
				if (resp_empty_i)
				begin
					state_next = SEQ_IDLE;
				end
			end
			default:
			begin
				state_next = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			lf_seen <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// Sticky until the user has read the reply out
			if (state == SEQ_DELIVER && resp_empty_i)
			begin
				lf_seen <= 1'b0;
			end
			else if (busy_o && line_feed_i)
			begin
				lf_seen <= 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) link.start |-> !link.busy)
		else $error("byte start while transmitter busy");

endmodule

`default_nettype wire

//--- source/bt_bridge.sv
// Top level of the AT-command bridge, connecting user FIFO ports to the Bluetooth UART lines
`timescale 1ns/1ps
`default_nettype none

module bt_bridge
	import bt_link_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire cmd_valid_i,
	input wire byte_t cmd_data_i,
	output logic cmd_ready_o,
	input wire send_i,
	input wire bit_cycles_t cpd_i,
	input wire bit_cycles_t spacing_i,
	output logic txd_o,
	input wire rxd_i,
	input wire resp_pop_i,
	output byte_t resp_data_o,
	output logic resp_valid_o,
	output logic resp_done_o,
	output logic busy_o
);

	byte_t cmd_head;
	logic cmd_full;
	logic cmd_empty;
	logic cmd_pop;
	logic resp_full;
	logic resp_empty;
	logic rx_valid;
	byte_t rx_byte;
	logic rx_line_feed;

	uart_byte_if link ();

	// No new commands while a transfer is in flight
	assign cmd_ready_o = !cmd_full && !busy_o;
	assign resp_valid_o = !resp_empty;

	byte_fifo #(
		.DEPTH(CMD_DEPTH)
	) cmd_fifo (
		.clock(clock),
		.reset(reset),
		.push_i(cmd_valid_i && cmd_ready_o),
		.push_data_i(cmd_data_i),
		.pop_i(cmd_pop),
		.head_o(cmd_head),
		.full_o(cmd_full),
		.empty_o(cmd_empty)
	);

	// Bytes arriving into a full response FIFO are lost
	byte_fifo #(
		.DEPTH(RESP_DEPTH)
	) resp_fifo (
		.clock(clock),
		.reset(reset),
		.push_i(rx_valid && !resp_full),
		.push_data_i(rx_byte),
		.pop_i(resp_pop_i && resp_valid_o),
		.head_o(resp_data_o),
		.full_o(resp_full),
		.empty_o(resp_empty)
	);

	at_sequencer sequencer (
		.clock(clock),
		.reset(reset),
		.send_i(send_i),
		.cmd_empty_i(cmd_empty),
		.cmd_head_i(cmd_head),
		.cmd_pop_o(cmd_pop),
		.link(link.sender),
		.line_feed_i(rx_line_feed && !resp_full),
		.resp_empty_i(resp_empty),
		.busy_o(busy_o),
		.resp_done_o(resp_done_o)
	);

	uart_tx_engine tx_engine (
		.clock(clock),
		.reset(reset),
		.cpd_i(cpd_i),
		.spacing_i(spacing_i),
		.link(link.transmitter),
		.txd_o(txd_o)
	);

	uart_rx_engine rx_engine (
		.clock(clock),
		.reset(reset),
		.cpd_i(cpd_i),
		.rxd_i(rxd_i),
		.byte_valid_o(rx_valid),
		.byte_o(rx_byte),
		.line_feed_o(rx_line_feed)
	);

endmodule

`default_nettype wire

//--- source/bt_link_pkg.sv
// Shared byte and timing types plus FIFO and framing constants, imported by the bridge RTL and its testbench
`default_nettype none

package bt_link_pkg;

	// One data byte on the UART or in a FIFO
	typedef logic [7:0] byte_t;

	// Cycles per UART bit, also used for the inter-byte gap
	typedef logic [9:0] bit_cycles_t;

	// FIFO sizes
	localparam int CMD_DEPTH = 16;
	localparam int RESP_DEPTH = 32;

	// A reply from the module ends with this byte
	localparam byte_t LINE_FEED = 8'h0A;

	// 8N1 framing
	localparam int FRAME_DATA_BITS = 8;

endpackage

`default_nettype wire

//--- source/byte_fifo.sv
// Synchronous first-word fall-through byte FIFO, instantiated for both command and response storage
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
	import bt_link_pkg::*;
#(
	parameter int DEPTH = 16
)(
	input wire clock,
	input wire reset,
	input wire push_i,
	input wire byte_t push_data_i,
	input wire pop_i,
	output byte_t head_o,
	output logic full_o,
	output logic empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	byte_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign full_o = (count == CNT_W'(DEPTH));
	assign empty_o = (count == '0);
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	// Head is visible without a read cycle
	assign head_o = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Callers gate their own strobes
	assert property (@(posedge clock) disable iff (reset) push_i |-> !full_o)
		else $error("push while FIFO full");
	assert property (@(posedge clock) disable iff (reset) pop_i |-> !empty_o)
		else $error("pop while FIFO empty");

endmodule

`default_nettype wire

//--- source/uart_byte_if.sv
// Byte handoff between the command sequencer and the UART transmitter, one transfer per start pulse
`timescale 1ns/1ps
`default_nettype none

interface uart_byte_if
	import bt_link_pkg::*;
();

	// Sequencer side
	logic start;
	byte_t data;

	// Transmitter side
	logic busy;
	logic done;

	modport sender (
		output start,
		output data,
		input busy,
		input done
	);

	modport transmitter (
		input start,
		input data,
		output busy,
		output done
	);

endinterface

`default_nettype wire

//--- source/uart_rx_engine.sv
// UART receiver with mid-bit sampling, emits each good byte and marks line-feed terminators
`timescale 1ns/1ps
`default_nettype none

module uart_rx_engine
	import bt_link_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire bit_cycles_t cpd_i,
	input wire rxd_i,
	output logic byte_valid_o,
	output byte_t byte_o,
	output logic line_feed_o
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	bit_cycles_t cnt;
	logic [$clog2(FRAME_DATA_BITS)-1:0] bit_idx;
	byte_t shift_q;
	logic rx_meta;
	logic rx_s;
	logic rx_d;
	logic fall;
	logic half_end;
	logic bit_end;
	logic valid_q;
	logic lf_q;

	assign fall = rx_d && !rx_s;
	assign half_end = (cnt == (cpd_i >> 1) - 1'b1);
	assign bit_end = (cnt == cpd_i - 1'b1);

	assign byte_valid_o = valid_q;
	assign line_feed_o = lf_q;
	assign byte_o = shift_q;

	// Two flops for metastability, a third for edge detection
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
			rx_d <= 1'b1;
		end
		else
		begin
			rx_meta <= rxd_i;
			rx_s <= rx_meta;
			rx_d <= rx_s;
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == RX_DATA && bit_end)
		begin
			shift_q <= {rx_s, shift_q[FRAME_DATA_BITS-1:1]};
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
			lf_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			lf_q <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					cnt <= '0;
					if (fall)
					begin
						state <= RX_START;
					end
				end
				RX_START:
				begin
					// Half a bit in, the start bit must still be low
					if (half_end)
					begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_s ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (bit_end)
					begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (int'(bit_idx) == FRAME_DATA_BITS - 1)
						begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP:
				begin
					if (bit_end)
					begin
						cnt <= '0;
						state <= RX_IDLE;
						// Framing error drops the byte
						valid_q <= rx_s;
						lf_q <= rx_s && (shift_q == LINE_FEED);
					end
				end
				default:
				begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/uart_tx_engine.sv
// UART transmitter for one byte per start pulse, followed by a programmable idle gap before done
`timescale 1ns/1ps
`default_nettype none

module uart_tx_engine
	import bt_link_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire bit_cycles_t cpd_i,
	input wire bit_cycles_t spacing_i,
	uart_byte_if.transmitter link,
	output logic txd_o
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		TX_GAP
	} tx_state_t;

	tx_state_t state;
	bit_cycles_t cnt;
	logic [$clog2(FRAME_DATA_BITS)-1:0] bit_idx;
	byte_t shift_q;
	logic done_q;
	logic bit_end;
	logic gap_end;

	assign bit_end = (cnt == cpd_i - 1'b1);
	assign gap_end = (cnt == spacing_i - 1'b1);

	assign link.busy = (state != TX_IDLE);
	assign link.done = done_q;

	// Line is low only for the start bit, LSB first during data
	assign txd_o = (state == TX_START) ? 1'b0 :
		(state == TX_DATA) ? shift_q[0] : 1'b1;

	always_ff @(posedge clock)
	begin
		if (state == TX_IDLE && link.start)
		begin
			shift_q <= link.data;
		end
		else if (state == TX_DATA && bit_end)
		begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				TX_IDLE:
				begin
					cnt <= '0;
					if (link.start)
					begin
						state <= TX_START;
					end
				end
				TX_START:
				begin
					if (bit_end)
					begin
						cnt <= '0;
						bit_idx <= '0;
						state <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					if (bit_end)
					begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (int'(bit_idx) == FRAME_DATA_BITS - 1)
						begin
							state <= TX_STOP;
						end
					end
				end
				TX_STOP:
				begin
					if (bit_end)
					begin
						cnt <= '0;
						// Zero spacing skips the gap entirely
						if (spacing_i == '0)
						begin
							state <= TX_IDLE;
							done_q <= 1'b1;
						end
						else
						begin
							state <= TX_GAP;
						end
					end
				end
				TX_GAP:
				begin
					if (gap_end)
					begin
						cnt <= '0;
						state <= TX_IDLE;
						done_q <= 1'b1;
					end
				end
				default:
				begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) (state == TX_IDLE) |-> txd_o)
		else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

//--- tests/bt_bridge_tb.sv
// Self-checking testbench for the AT-command bridge, acting as both the user and the Bluetooth module
`timescale 1ns/1ps
`default_nettype none

module bt_bridge_tb
	import bt_link_pkg::*;
();

	localparam int CPD_CYCLES = 4;
	localparam int SPACING_CYCLES = 6;
	// Roughly 50 cycles per byte, two exchanges of 16 + 8 bytes plus the directed ones, with margin
	localparam int MAX_CYCLES = 20000;

	logic clock = 1'b0;
	logic reset;
	logic cmd_valid;
	byte_t cmd_data;
	logic cmd_ready;
	logic send;
	bit_cycles_t cpd;
	bit_cycles_t spacing;
	logic txd;
	logic rxd;
	logic resp_pop;
	byte_t resp_data;
	logic resp_valid;
	logic resp_done;
	logic busy;

	// Accepted but not yet seen on txd
	byte_t expected_cmd[$];
	byte_t expected_resp[$];
	byte_t cmd_plan[$];
	byte_t reply_plan[$];
	bit lf_sent;
	integer seed;
	int cycle_count = 0;

	bt_bridge uut (
		.clock(clock),
		.reset(reset),
		.cmd_valid_i(cmd_valid),
		.cmd_data_i(cmd_data),
		.cmd_ready_o(cmd_ready),
		.send_i(send),
		.cpd_i(cpd),
		.spacing_i(spacing),
		.txd_o(txd),
		.rxd_i(rxd),
		.resp_pop_i(resp_pop),
		.resp_data_o(resp_data),
		.resp_valid_o(resp_valid),
		.resp_done_o(resp_done),
		.busy_o(busy)
	);

	always #20 clock = ~clock;

	task automatic stop_on_failure();
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string signal_name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %0t %s expected %0h got %0h", $time, signal_name, expected, actual);
		stop_on_failure();
	endtask

	task automatic report_problem(input string what);
		$display("%0t: %s", $time, what);
		stop_on_failure();
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			report_problem("timeout, the DUT never finished the exchange");
		end
	end

	// Checks that hold on every cycle
	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (busy)
			begin
				assert (!cmd_ready) else report_mismatch("cmd_ready_o", 0, 32'(cmd_ready));
			end
			if (resp_done)
			begin
				assert (lf_sent) else report_problem("resp_done_o rose before the line feed was sent");
			end
		end
	end

	task automatic check_reset_state();
		assert (txd) else report_mismatch("txd_o", 1, 32'(txd));
		assert (cmd_ready) else report_mismatch("cmd_ready_o", 1, 32'(cmd_ready));
		assert (!busy) else report_mismatch("busy_o", 0, 32'(busy));
		assert (!resp_valid) else report_mismatch("resp_valid_o", 0, 32'(resp_valid));
		assert (!resp_done) else report_mismatch("resp_done_o", 0, 32'(resp_done));
	endtask

	// Entered on the first low sample, returns on the first sample after the stop bit
	task automatic capture_frame(output byte_t value);
		logic level;
		int bit_pos;
		int cycle;
		value = '0;
		for (bit_pos = 0; bit_pos < FRAME_DATA_BITS + 2; bit_pos++)
		begin
			level = txd;
			if (bit_pos >= 1 && bit_pos <= FRAME_DATA_BITS)
			begin
				// LSB arrives first
				value = {level, value[7:1]};
			end
			else
			begin
				assert (level == (bit_pos != 0))
					else report_mismatch("txd_o", 32'(bit_pos != 0), 32'(level));
			end
			for (cycle = 0; cycle < CPD_CYCLES; cycle++)
			begin
				assert (txd == level) else report_mismatch("txd_o", 32'(level), 32'(txd));
				@(negedge clock);
			end
		end
	endtask

	// Bluetooth module side, receive path
	initial
	begin : line_monitor
		int gap;
		byte_t got;
		byte_t want;
		gap = SPACING_CYCLES;
		@(negedge clock);
		forever
		begin
			if (!reset && !txd)
			begin
				assert (gap >= SPACING_CYCLES)
					else report_problem("start bit on txd_o came before the byte spacing elapsed");
				capture_frame(got);
				assert (expected_cmd.size() > 0)
					else report_problem("txd_o carried a byte that was never accepted as a command");
				want = expected_cmd.pop_front();
				assert (got == want) else report_mismatch("txd_o byte", 32'(want), 32'(got));
				gap = 0;
			end
			else
			begin
				gap = gap + 1;
				@(negedge clock);
			end
		end
	end

	// Called on a rising edge, returns on the edge that accepted the byte
	task automatic push_command(input byte_t value);
		cmd_valid <= 1'b1;
		cmd_data <= value;
		@(negedge clock);
		while (!cmd_ready)
		begin
			@(negedge clock);
		end
		@(posedge clock);
		expected_cmd.push_back(value);
	endtask

	task automatic start_transfer();
		lf_sent = 1'b0;
		@(posedge clock);
		send <= 1'b1;
		@(posedge clock);
		send <= 1'b0;
		@(negedge clock);
		assert (busy) else report_mismatch("busy_o", 1, 32'(busy));
	endtask

	task automatic drive_rx_frame(input byte_t value, input bit last);
		logic [FRAME_DATA_BITS+1:0] frame;
		int bit_pos;
		frame = {1'b1, value, 1'b0};
		for (bit_pos = 0; bit_pos < FRAME_DATA_BITS + 2; bit_pos++)
		begin
			@(posedge clock);
			rxd <= frame[0];
			frame = frame >> 1;
			// Line feed is out once its stop bit is on the line
			if (last && bit_pos == FRAME_DATA_BITS + 1)
			begin
				lf_sent = 1'b1;
			end
			repeat (CPD_CYCLES - 1) @(posedge clock);
		end
	endtask

	task automatic deliver_reply();
		int i;
		while (expected_cmd.size() > 0)
		begin
			@(negedge clock);
		end
		for (i = 0; i < reply_plan.size(); i++)
		begin
			drive_rx_frame(reply_plan[i], i == reply_plan.size() - 1);
			expected_resp.push_back(reply_plan[i]);
			repeat (2) @(posedge clock);
		end
		while (!resp_done)
		begin
			@(negedge clock);
		end
	endtask

	task automatic collect_reply();
		byte_t want;
		while (expected_resp.size() > 0)
		begin
			@(negedge clock);
			assert (resp_valid) else report_problem("response FIFO ran empty before the reply was read");
			want = expected_resp.pop_front();
			assert (resp_data == want) else report_mismatch("resp_data_o", 32'(want), 32'(resp_data));
			@(posedge clock);
			resp_pop <= 1'b1;
			@(posedge clock);
			resp_pop <= 1'b0;
		end
		// Sequencer leaves DELIVER one cycle after the FIFO empties
		@(negedge clock);
		assert (!resp_valid) else report_mismatch("resp_valid_o", 0, 32'(resp_valid));
		assert (busy) else report_mismatch("busy_o", 1, 32'(busy));
		@(negedge clock);
		assert (!busy) else report_mismatch("busy_o", 0, 32'(busy));
		assert (!resp_done) else report_mismatch("resp_done_o", 0, 32'(resp_done));
	endtask

	task automatic run_exchange();
		int i;
		@(posedge clock);
		for (i = 0; i < cmd_plan.size(); i++)
		begin
			push_command(cmd_plan[i]);
		end
		cmd_valid <= 1'b0;
		start_transfer();
		deliver_reply();
		collect_reply();
	endtask

	initial
	begin : stimulus
		int i;
		int t;
		int cmd_len;
		int reply_len;
		byte_t b;
		seed = 32'h44b5_f271;
		lf_sent = 1'b0;
		reset <= 1'b1;
		cmd_valid <= 1'b0;
		cmd_data <= '0;
		send <= 1'b0;
		cpd <= bit_cycles_t'(CPD_CYCLES);
		spacing <= bit_cycles_t'(SPACING_CYCLES);
		rxd <= 1'b1;
		resp_pop <= 1'b0;
		repeat (5)
		begin
			@(negedge clock);
			check_reset_state();
		end
		@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_reset_state();

		// Directed AT / OK exchange
		cmd_plan = '{8'h41, 8'h54, 8'h0D, LINE_FEED};
		reply_plan = '{8'h4F, 8'h4B, 8'h0D, LINE_FEED};
		run_exchange();

		// Fill the command FIFO, then keep pushing while full and while busy
		reply_plan = '{8'h4F, 8'h4B, LINE_FEED};
		@(posedge clock);
		for (i = 0; i < CMD_DEPTH; i++)
		begin
			push_command(byte_t'($random(seed)));
		end
		cmd_data <= 8'hEE;
		@(negedge clock);
		assert (!cmd_ready) else report_mismatch("cmd_ready_o", 0, 32'(cmd_ready));
		repeat (3) @(posedge clock);
		cmd_valid <= 1'b0;
		start_transfer();
		@(posedge clock);
		cmd_valid <= 1'b1;
		cmd_data <= 8'h5A;
		repeat (120) @(posedge clock);
		cmd_valid <= 1'b0;
		deliver_reply();
		collect_reply();

		// Two random exchanges back to back
		for (t = 0; t < 2; t++)
		begin
			cmd_plan.delete();
			reply_plan.delete();
			cmd_len = ($random(seed) & 15) + 1;
			reply_len = ($random(seed) & 7) + 1;
			for (i = 0; i < cmd_len; i++)
			begin
				cmd_plan.push_back(byte_t'($random(seed)));
			end
			for (i = 1; i < reply_len; i++)
			begin
				b = byte_t'($random(seed));
				// Only the last reply byte may end the line
				if (b == LINE_FEED)
				begin
					b = 8'h4F;
				end
				reply_plan.push_back(b);
			end
			reply_plan.push_back(LINE_FEED);
			run_exchange();
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
